// ==== hdl/lane_collect.sv ====
`timescale 1ns/1ps

module lane_collect #(
   parameter int LANES      = 4,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic [LANES-1:0]      i_push,
   input  merge_pkg::lane_word_t i_push_word [LANES],
   output logic [LANES-1:0]      o_credit,     // one pulse per pop of a lane.
   output logic                  o_out_valid,
   output merge_pkg::out_word_t  o_out_word,
   input  logic                  i_out_ready
);
   import merge_pkg::*;

   lane_word_t        head [LANES];
   logic [LANES-1:0]  empty;
   logic [LANE_W-1:0] rr_ptr;    // first lane to look at next time.
   logic [LANE_W-1:0] grant;
   logic              grant_ok;
   logic              load;      // the output register takes a new word.

   for (genvar l = 0; l < LANES; l++) begin : g_fifo
      sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
         .i_clk   (i_clk),
         .i_rst_n (i_rst_n),
         .i_wr    (i_push[l]),
         .i_wdata (i_push_word[l]),
         .i_rd    (o_credit[l]),
         .o_rdata (head[l]),
         .o_empty (empty[l])
      );
   end

   // ======================================================================
   // round-robin arbiter.
   // ======================================================================
   // the search runs downward, so the nearest lane after rr_ptr wins.
   always_comb begin
      int idx;
      grant    = rr_ptr;
      grant_ok = 1'b0;
      for (int i = LANES - 1; i >= 0; i--) begin
         idx = (int'(rr_ptr) + i) % LANES;
         if (!empty[idx]) begin
            grant    = LANE_W'(idx);
            grant_ok = 1'b1;
         end
      end
      load     = grant_ok && (!o_out_valid || i_out_ready);
      o_credit = '0;
      if (load) o_credit[grant] = 1'b1;  // the pop itself is the credit.
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_out_valid <= 1'b0;
         rr_ptr      <= '0;
      end else if (load) begin
         o_out_valid <= 1'b1;
         rr_ptr      <= (grant == LANE_W'(LANES - 1)) ? '0 : grant + 1'b1;
      end else if (i_out_ready) begin
         o_out_valid <= 1'b0;  // word taken and nothing waiting.
      end
   end

   always_ff @(posedge i_clk) begin
      if (load) begin
         o_out_word <= '{lane: grant, key: head[grant].key, last: head[grant].last};
      end
   end

endmodule

// ==== hdl/lane_dispatch.sv ====
`timescale 1ns/1ps

module lane_dispatch #(
   parameter int LANES      = 4,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_in_valid,
   input  merge_pkg::in_word_t   i_in_word,
   output logic                  o_in_ready,
   output logic [LANES-1:0]      o_wr_a,      // per-lane side A write.
   output logic [LANES-1:0]      o_wr_b,      // per-lane side B write.
   output merge_pkg::lane_word_t o_wdata,     // shared by all lanes.
   input  logic [LANES-1:0]      i_credit_a,  // side A pops in each lane.
   input  logic [LANES-1:0]      i_credit_b   // side B pops in each lane.
);
   import merge_pkg::*;

   localparam int CW = $clog2(FIFO_DEPTH + 1);

   logic [CW-1:0] cnt_a [LANES];  // free side A slots per lane.
   logic [CW-1:0] cnt_b [LANES];  // free side B slots per lane.
   logic          run_q;          // low during reset, keeps ready low.
   logic          credit_ok;
   logic          accept;

   // ready depends on the word itself, since its lane and side pick a counter.
   always_comb begin
      credit_ok = 1'b0;
      for (int l = 0; l < LANES; l++) begin
         if (i_in_word.lane == LANE_W'(l)) begin
            credit_ok = i_in_word.side ? (cnt_b[l] != '0) : (cnt_a[l] != '0);
         end
      end
   end

   assign o_in_ready = run_q & credit_ok;
   assign accept     = i_in_valid & o_in_ready;
   assign o_wdata    = '{key: i_in_word.key, last: i_in_word.last};

   always_comb begin
      for (int l = 0; l < LANES; l++) begin
         o_wr_a[l] = accept && (i_in_word.lane == LANE_W'(l)) && !i_in_word.side;
         o_wr_b[l] = accept && (i_in_word.lane == LANE_W'(l)) && i_in_word.side;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         run_q <= 1'b0;
         for (int l = 0; l < LANES; l++) begin
            cnt_a[l] <= CW'(FIFO_DEPTH);
            cnt_b[l] <= CW'(FIFO_DEPTH);
         end
      end else begin
         run_q <= 1'b1;
         for (int l = 0; l < LANES; l++) begin
            cnt_a[l] <= cnt_a[l] - CW'(o_wr_a[l]) + CW'(i_credit_a[l]);
            cnt_b[l] <= cnt_b[l] - CW'(o_wr_b[l]) + CW'(i_credit_b[l]);
         end
      end
   end

   // a lane never returns more credits than words were written into it.
   for (genvar l = 0; l < LANES; l++) begin : g_chk
      a_credit_bound: assert property (@(posedge i_clk) disable iff (!i_rst_n)
         (cnt_a[l] <= CW'(FIFO_DEPTH)) && (cnt_b[l] <= CW'(FIFO_DEPTH)));
   end

endmodule

// ==== hdl/merge_control.sv ====
`timescale 1ns/1ps

module merge_control (
   input  logic i_clk,
   input  logic i_rst_n,
   input  logic i_a_empty,        // side A FIFO has no head.
   input  logic i_b_empty,        // side B FIFO has no head.
   input  logic i_a_end,          // side A head is a terminator.
   input  logic i_b_end,          // side B head is a terminator.
   input  logic i_a_last,         // last flag of the side A head.
   input  logic i_b_last,         // last flag of the side B head.
   input  logic i_a_le_b,         // side A head key is not above side B.
   input  logic i_out_credit_ok,  // room downstream for one more word.
   output logic o_pop_a,
   output logic o_pop_b,
   output logic o_emit_key,       // push the popped key downstream.
   output logic o_emit_end        // push one run terminator downstream.
);
   import merge_pkg::*;

   ctrl_state_t state;
   ctrl_state_t state_nx;

   // ======================================================================
   // next state and pop decisions.
   // ======================================================================
   // a state change alone moves no data, so it does not need a credit.
   // every pop pushes exactly one word, so every pop waits for a credit.
   always_comb begin
      state_nx   = state;
      o_pop_a    = 1'b0;
      o_pop_b    = 1'b0;
      o_emit_key = 1'b0;
      o_emit_end = 1'b0;
      case (state)
         NOMINAL: begin
            if (!i_a_empty && !i_b_empty && i_a_end && i_b_end) begin
               state_nx = TOGGLE;  // both runs ended at once.
            end else if (!i_a_empty && i_a_end) begin
               state_nx = DONE_A;
            end else if (!i_b_empty && i_b_end) begin
               state_nx = DONE_B;
            end else if (!i_a_empty && !i_b_empty && i_out_credit_ok) begin
               o_pop_a    = i_a_le_b;   // ties go to side A.
               o_pop_b    = !i_a_le_b;
               o_emit_key = 1'b1;
            end
         end
         DONE_A: begin
            // side A waits on its terminator while side B drains.
            if (!i_b_empty && i_b_end) begin
               state_nx = TOGGLE;
            end else if (!i_b_empty && i_out_credit_ok) begin
               o_pop_b    = 1'b1;
               o_emit_key = 1'b1;
            end
         end
         DONE_B: begin
            if (!i_a_empty && i_a_end) begin
               state_nx = TOGGLE;
            end else if (!i_a_empty && i_out_credit_ok) begin
               o_pop_a    = 1'b1;
               o_emit_key = 1'b1;
            end
         end
         TOGGLE: begin
            // both terminators leave together as one merged terminator.
            if (i_out_credit_ok) begin
               o_pop_a    = 1'b1;
               o_pop_b    = 1'b1;
               o_emit_end = 1'b1;
               state_nx   = (i_a_last && i_b_last) ? FINISHED : NOMINAL;
            end
         end
         FINISHED: state_nx = FINISHED;  // only a reset restarts the lane.
         default:  state_nx = NOMINAL;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state <= NOMINAL;
      end else begin
         state <= state_nx;
      end
   end

   // a pop always names a side whose FIFO holds a word.
   a_pop_nonempty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(o_pop_a && i_a_empty) && !(o_pop_b && i_b_empty));

   // the two terminators stay at the FIFO heads until TOGGLE pops them.
   a_toggle_heads: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (state == TOGGLE) |-> (!i_a_empty && !i_b_empty && i_a_end && i_b_end));

endmodule

// ==== hdl/merge_lane.sv ====
`timescale 1ns/1ps

module merge_lane #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_wr_a,        // write into the side A FIFO.
   input  logic                  i_wr_b,        // write into the side B FIFO.
   input  merge_pkg::lane_word_t i_wdata,
   output logic                  o_credit_a,    // one pulse per side A pop.
   output logic                  o_credit_b,    // one pulse per side B pop.
   output logic                  o_push,        // merged word to collect.
   output merge_pkg::lane_word_t o_push_word,
   input  logic                  i_out_credit   // collect freed one slot.
);
   import merge_pkg::*;

   localparam int CW = $clog2(FIFO_DEPTH + 1);

   lane_word_t    a_head;
   lane_word_t    b_head;
   logic          a_empty;
   logic          b_empty;
   logic          a_end;
   logic          b_end;
   logic          a_le_b;
   logic          pop_a;
   logic          pop_b;
   logic          emit_key;
   logic          emit_end;
   logic [CW-1:0] out_cnt;  // free slots in this lane's output FIFO.

   sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo_a (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_wr    (i_wr_a),
      .i_wdata (i_wdata),
      .i_rd    (pop_a),
      .o_rdata (a_head),
      .o_empty (a_empty)
   );

   sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo_b (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_wr    (i_wr_b),
      .i_wdata (i_wdata),
      .i_rd    (pop_b),
      .o_rdata (b_head),
      .o_empty (b_empty)
   );

   assign a_end  = (a_head.key == '0);         // terminator on side A.
   assign b_end  = (b_head.key == '0);         // terminator on side B.
   assign a_le_b = (a_head.key <= b_head.key);  // key comparator.

   merge_control u_ctrl (
      .i_clk           (i_clk),
      .i_rst_n         (i_rst_n),
      .i_a_empty       (a_empty),
      .i_b_empty       (b_empty),
      .i_a_end         (a_end),
      .i_b_end         (b_end),
      .i_a_last        (a_head.last),
      .i_b_last        (b_head.last),
      .i_a_le_b        (a_le_b),
      .i_out_credit_ok (out_cnt != '0),
      .o_pop_a         (pop_a),
      .o_pop_b         (pop_b),
      .o_emit_key      (emit_key),
      .o_emit_end      (emit_end)
   );

   assign o_credit_a = pop_a;  // each pop frees one input slot.
   assign o_credit_b = pop_b;
   assign o_push     = emit_key | emit_end;

   // a terminator carries last only when both sides ended their final run.
   always_comb begin
      o_push_word = '0;
      if (emit_end) begin
         o_push_word.last = a_head.last & b_head.last;
      end else if (emit_key) begin
         o_push_word.key = pop_a ? a_head.key : b_head.key;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         out_cnt <= CW'(FIFO_DEPTH);  // collect FIFO starts empty.
      end else begin
         out_cnt <= out_cnt - CW'(o_push) + CW'(i_out_credit);
      end
   end

   // the FSM only pushes while collect still has a free slot for this lane.
   a_credit_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_push |-> (out_cnt != '0));

endmodule

// ==== hdl/merge_pkg.sv ====
package merge_pkg;

   // ======================================================================
   // word widths.
   // ======================================================================
   localparam int KEY_W  = 16;  // a key of zero ends a run.
   localparam int LANE_W = 2;   // enough index bits for four lanes.

   // ======================================================================
   // stream words.
   // ======================================================================

   // a word as it arrives on the input port, tagged with lane and side.
   typedef struct packed {
      logic [LANE_W-1:0] lane;  // destination lane.
      logic              side;  // 0 for side A, 1 for side B.
      logic [KEY_W-1:0]  key;   // sort key where zero is a terminator.
      logic              last;  // set on the terminator of the final run.
   } in_word_t;

   // the part of a word that a lane keeps in its FIFOs.
   typedef struct packed {
      logic [KEY_W-1:0] key;
      logic             last;
   } lane_word_t;

   // a merged word on the output port, tagged with the lane it came from.
   typedef struct packed {
      logic [LANE_W-1:0] lane;
      logic [KEY_W-1:0]  key;
      logic              last;
   } out_word_t;

   // merge FSM states.
   typedef enum logic [2:0] {
      NOMINAL  = 3'b000,  // both runs open, the smaller head goes out.
      TOGGLE   = 3'b001,  // both heads are terminators.
      DONE_A   = 3'b010,  // side A has ended its run, side B drains.
      DONE_B   = 3'b011,  // side B has ended its run, side A drains.
      FINISHED = 3'b100   // final pair merged, the lane is idle.
   } ctrl_state_t;

endpackage

// ==== hdl/run_merger_top.sv ====
`timescale 1ns/1ps

module run_merger_top #(
   parameter int LANES      = 4,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_in_valid,
   input  merge_pkg::in_word_t  i_in_word,
   output logic                 o_in_ready,
   output logic                 o_out_valid,
   output merge_pkg::out_word_t o_out_word,
   input  logic                 i_out_ready
);
   import merge_pkg::*;

   logic [LANES-1:0] wr_a;
   logic [LANES-1:0] wr_b;
   logic [LANES-1:0] credit_a;
   logic [LANES-1:0] credit_b;
   logic [LANES-1:0] push;
   logic [LANES-1:0] out_credit;
   lane_word_t       wdata;
   lane_word_t       push_word [LANES];

   lane_dispatch #(.LANES(LANES), .FIFO_DEPTH(FIFO_DEPTH)) u_dispatch (
      .i_clk      (i_clk),
      .i_rst_n    (i_rst_n),
      .i_in_valid (i_in_valid),
      .i_in_word  (i_in_word),
      .o_in_ready (o_in_ready),
      .o_wr_a     (wr_a),
      .o_wr_b     (wr_b),
      .o_wdata    (wdata),
      .i_credit_a (credit_a),
      .i_credit_b (credit_b)
   );

   // one merge lane per lane index, all fed from the same write data bus.
   for (genvar l = 0; l < LANES; l++) begin : g_lane
      merge_lane #(.FIFO_DEPTH(FIFO_DEPTH)) u_lane (
         .i_clk        (i_clk),
         .i_rst_n      (i_rst_n),
         .i_wr_a       (wr_a[l]),
         .i_wr_b       (wr_b[l]),
         .i_wdata      (wdata),
         .o_credit_a   (credit_a[l]),
         .o_credit_b   (credit_b[l]),
         .o_push       (push[l]),
         .o_push_word  (push_word[l]),
         .i_out_credit (out_credit[l])
      );
   end

   lane_collect #(.LANES(LANES), .FIFO_DEPTH(FIFO_DEPTH)) u_collect (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_push      (push),
      .i_push_word (push_word),
      .o_credit    (out_credit),
      .o_out_valid (o_out_valid),
      .o_out_word  (o_out_word),
      .i_out_ready (i_out_ready)
   );

endmodule

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_wr,     // write strobe.
   input  merge_pkg::lane_word_t i_wdata,
   input  logic                  i_rd,     // pop strobe.
   output merge_pkg::lane_word_t o_rdata,  // head word that is valid while not empty.
   output logic                  o_empty
);
   import merge_pkg::*;

   localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CW = $clog2(FIFO_DEPTH + 1);

   lane_word_t    mem [FIFO_DEPTH];  // word storage.
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;             // words held, from 0 to FIFO_DEPTH.

   // pointers wrap at FIFO_DEPTH, which need not be a power of two.
   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
      return (ptr == AW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_wr) wr_ptr <= next_ptr(wr_ptr);  // advance after each write.
         if (i_rd) rd_ptr <= next_ptr(rd_ptr);  // advance after each pop.
         count <= count + CW'(i_wr) - CW'(i_rd);
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_wr) begin
         mem[wr_ptr] <= i_wdata;
      end
   end

   // show-ahead read, so the head is there one cycle after the write.
   assign o_rdata = mem[rd_ptr];
   assign o_empty = (count == '0);

   // the credit counters upstream must never let a write hit a full FIFO.
   a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_wr |-> (count != CW'(FIFO_DEPTH)));

   // the consumer must only pop a word that it can see.
   a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_rd |-> !o_empty);

endmodule

// ==== run_merger.f ====
hdl/merge_pkg.sv
hdl/sync_fifo.sv
hdl/merge_control.sv
hdl/merge_lane.sv
hdl/lane_dispatch.sv
hdl/lane_collect.sv
hdl/run_merger_top.sv
tests/tb_run_merger.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the run merger testbench with Verilator and run it.
# The exit status is zero only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module tb_run_merger \
   -Mdir "$BUILD_DIR" \
   -f run_merger.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/Vtb_run_merger" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "All checks passed" "$LOG_FILE"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi

// ==== tests/run_merger_testdata.txt ====
// one hex word per entry, digits: kind, lane, side, key (four digits), last.
// kind 1 is an input word in drive order, kind 2 an expected output word of its lane.
// lane 0: two interleaved runs, both terminators carry last.
10000010 10100020 10000040 10100030 10000060 10100070 10000001 10100001
20000010 20000020 20000030 20000040 20000060 20000070 20000001
// lane 3: side A run is longer, final pair.
13000100 13100150 13000200 13100250 13000300 13100001 13000001
23000100 23000150 23000200 23000250 23000300 23000001
// lane 1, first pair: equal keys on both sides, side A copies first.
11000050 11100050 11000050 11100080 11000090 11100000 11000000
21000050 21000050 21000050 21000080 21000090 21000000
// lane 2: side B run is empty, side A passes through.
12000020 12100001 12000070 12000001
22000020 22000070 22000001
// lane 1, second pair: side A run is empty, side B passes through.
11000001 11100030 11100040 11100001
21000030 21000040 21000001

// ==== tests/tb_run_merger.sv ====
`timescale 1ns/1ps

module tb_run_merger;
   import merge_pkg::*;

   localparam int LANES      = 4;
   localparam int FIFO_DEPTH = 4;
   localparam int MAX_WORDS  = 128;  // size of the stimulus memory.
   localparam int MAX_EXP    = 32;   // expected words kept per lane.
   localparam int STALL_CYC  = 40;   // watchdog budget per data word.

   logic        i_clk;
   logic        i_rst_n;
   logic        i_in_valid;
   in_word_t    i_in_word;
   logic        o_in_ready;
   logic        o_out_valid;
   out_word_t   o_out_word;
   logic        i_out_ready;

   logic [31:0] data_mem [MAX_WORDS];     // raw words from the data file.
   out_word_t   exp_w [LANES][MAX_EXP];   // expected output, per lane in file order.
   int          exp_n [LANES];
   int          got_n [LANES];
   int          n_words;
   int          exp_total;
   int          got_total;
   int          edge_cnt;
   int          seed;
   logic        idle_req;                 // ask the driver for one idle cycle.
   logic        loaded;
   logic        seen_input;               // set once the first word was accepted.

   run_merger_top #(.LANES(LANES), .FIFO_DEPTH(FIFO_DEPTH)) uut (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_in_valid  (i_in_valid),
      .i_in_word   (i_in_word),
      .o_in_ready  (o_in_ready),
      .o_out_valid (o_out_valid),
      .o_out_word  (o_out_word),
      .i_out_ready (i_out_ready)
   );

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;  // 4 ns period.
   end

   // ======================================================================
   // helpers.
   // ======================================================================
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
         $display("Checks failed");
         $fatal(1, "run stopped at the first error");
      end
   endtask

   // kind 1 words are stimulus, kind 2 words go into the queue of their lane.
   task automatic load_data();
      logic [31:0] w;
      int          ln;
      for (int i = 0; i < MAX_WORDS; i++) begin
         data_mem[i] = '0;  // unused entries read as kind 0.
      end
      $readmemh("tests/run_merger_testdata.txt", data_mem);
      n_words   = 0;
      exp_total = 0;
      for (int l = 0; l < LANES; l++) begin
         exp_n[l] = 0;
         got_n[l] = 0;
      end
      for (int i = 0; i < MAX_WORDS; i++) begin
         w = data_mem[i];
         if (w[31:28] != 4'h0) n_words++;
         if (w[31:28] == 4'h2) begin
            ln = int'(w[27:24]);
            if (ln >= LANES || exp_n[ln] >= MAX_EXP) begin
               abort_run($sformatf("data word %0d names a bad lane or overflows it", i));
            end
            exp_w[ln][exp_n[ln]] = '{lane: LANE_W'(ln), key: w[19:4], last: w[0]};
            exp_n[ln]++;
            exp_total++;
         end
      end
      if (n_words == 0) abort_run("the data file holds no words");
   endtask

   // ======================================================================
   // random back-pressure and idle gaps from one draw per cycle.
   // ======================================================================
   always @(posedge i_clk) begin
      logic [31:0] rnd;
      rnd = $random(seed);
      i_out_ready <= rnd[2];                 // ready about half of the cycles.
      idle_req    <= (rnd[5:4] == 2'b00);    // a gap before about one word in four.
   end

   // the output monitor checks each lane against its own queue.
   always @(posedge i_clk) begin
      int ln;
      if (edge_cnt > 0 && !i_rst_n) begin
         compare_value("o_out_valid", 32'(o_out_valid), 32'h0);
         compare_value("o_in_ready", 32'(o_in_ready), 32'h0);
      end
      if (i_rst_n && !seen_input) compare_value("o_out_valid", 32'(o_out_valid), 32'h0);
      if (i_in_valid && o_in_ready) seen_input = 1'b1;
      if (o_out_valid && i_out_ready) begin
         ln = int'(o_out_word.lane);
         if (got_n[ln] >= exp_n[ln]) begin
            abort_run($sformatf("lane %0d sent a word after its final terminator", ln));
         end
         compare_value("o_out_word", 32'(o_out_word), 32'(exp_w[ln][got_n[ln]]));
         got_n[ln]++;
         got_total++;
      end
      edge_cnt++;
   end

   // ======================================================================
   // main sequence.
   // ======================================================================
   initial begin
      logic [31:0] w;
      seed        = 32'h9170afc5;
      i_rst_n     = 1'b0;
      i_in_valid  = 1'b0;
      i_in_word   = '0;
      i_out_ready = 1'b0;
      idle_req    = 1'b0;
      seen_input  = 1'b0;
      got_total   = 0;
      edge_cnt    = 0;
      loaded      = 1'b0;
      load_data();
      loaded = 1'b1;
      repeat (16) @(posedge i_clk);
      i_rst_n <= 1'b1;
      for (int i = 0; i < MAX_WORDS; i++) begin
         w = data_mem[i];
         if (w[31:28] == 4'h1) begin
            if (idle_req) begin
               i_in_valid <= 1'b0;
               @(posedge i_clk);
            end
            i_in_valid <= 1'b1;
            i_in_word  <= '{lane: w[25:24], side: w[20], key: w[19:4], last: w[0]};
            @(posedge i_clk);
            while (!o_in_ready) @(posedge i_clk);  // hold the word until taken.
         end
      end
      i_in_valid <= 1'b0;
      while (got_total < exp_total) @(posedge i_clk);
      repeat (60) @(posedge i_clk);  // any extra word would show up here.
      $display("lane FSM states: %s %s %s %s",
               uut.g_lane[0].u_lane.u_ctrl.state.name(),
               uut.g_lane[1].u_lane.u_ctrl.state.name(),
               uut.g_lane[2].u_lane.u_ctrl.state.name(),
               uut.g_lane[3].u_lane.u_ctrl.state.name());
      if (got_total == exp_total) begin
         $display("All checks passed");
         $finish;
      end else begin
         $display("received %0d words, expected %0d", got_total, exp_total);
         $display("Checks failed");
         $fatal(1, "word count wrong");
      end
   end

   // the budget grows with the number of words in the data file.
   initial begin
      int limit;
      wait (loaded);
      limit = 16 + STALL_CYC * n_words;
      repeat (limit) @(posedge i_clk);
      $display("output stalled, only %0d of %0d words arrived within %0d cycles",
               got_total, exp_total, limit);
      $display("Checks failed");
      $fatal(1, "watchdog expired");
   end

endmodule
